// ==== Makefile ====
# Verilator build and run of the decode stage testbench
TOP = tb_rv_decode
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== hdl/rv_alu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_alu_ctrl
(
    input  rv_decode_pkg::instr_t     i_instr,
    input  rv_decode_pkg::opc_class_e i_class,
    output rv_decode_pkg::alu_ctrl_t  o_alu_ctrl,
    output rv_decode_pkg::alu_res_t   o_alu_res
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic       f7_alt;     // funct7 bit 5 of sub and sra
    logic       is_branch, is_alu, no_inv, force_inv;

    assign funct3    = i_instr[14:12];
    assign f7_alt    = i_instr[30];
    assign is_branch = (i_class == cls_branch);
    assign is_alu    = (i_class == cls_op) || (i_class == cls_op_imm);
    assign no_inv    = (i_class inside {cls_lui, cls_auipc, cls_jal, cls_load,
                                        cls_store, cls_op_imm});

    assign force_inv = is_branch |
                       (is_alu & (funct3[2:1] == 2'b01)) |    // slt, sltu
                       (is_alu & (funct3 == f3_sr) & f7_alt);  // sra, srai

    assign o_alu_ctrl.add_override = (i_class inside {cls_lui, cls_auipc, cls_jal,
                                                      cls_load, cls_store});
    assign o_alu_ctrl.op1_inv_or_ecmp_inv = is_branch & funct3[0];
    assign o_alu_ctrl.op2_inverse = force_inv ? 1'b1 : (no_inv ? 1'b0 : f7_alt);

    always_comb
    begin
        o_alu_res = '0;
        if (is_branch)
            o_alu_res.cmp = 1'b1;
        else if ((i_class == cls_load) || (i_class == cls_store))
            o_alu_res.arith = 1'b1;     // address add
        else if (is_alu)
        begin
            case (funct3)
                f3_add:          o_alu_res.arith = (i_class == cls_op);  // addi uses zero group
                f3_sll, f3_sr:   o_alu_res.shift = 1'b1;
                f3_slt, f3_sltu: o_alu_res.cmp = 1'b1;
                f3_xor, f3_or,
                f3_and:          o_alu_res.bits = 1'b1;
                default:         o_alu_res = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_csr_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_csr_ctrl
(
    input  rv_decode_pkg::instr_t     i_instr,
    input  rv_decode_pkg::sys_op_e    i_sys_op,
    input  wire                       i_stall,
    output rv_decode_pkg::csr_ctrl_t  o_csr,
    output logic                      o_csr_ebreak,
    output logic                      o_inst_mret,
    output logic                      o_inst_csr_req
);
    import rv_decode_pkg::*;

    logic [2:0] funct3;
    logic       is_csr;
    logic       strobe_en;

    assign funct3    = i_instr[14:12];
    assign is_csr    = (i_sys_op == sys_csr);
    assign strobe_en = is_csr & !i_stall;  // no side effects while held

    assign o_csr.idx     = i_instr[31:20];
    assign o_csr.imm     = i_instr[19:15];  // uimm of the i forms
    assign o_csr.imm_sel = funct3[2];
    assign o_csr.write   = strobe_en & (funct3[1:0] == 2'b01);  // csrrw(i)
    assign o_csr.set     = strobe_en & (funct3[1:0] == 2'b10);  // csrrs(i)
    assign o_csr.clear   = strobe_en & (funct3[1:0] == 2'b11);  // csrrc(i)
    assign o_csr.read    = is_csr;

    assign o_inst_csr_req = is_csr;
    assign o_csr_ebreak   = (i_sys_op == sys_ebreak);
    assign o_inst_mret    = (i_sys_op == sys_mret);

endmodule

`default_nettype wire

// ==== hdl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    // base opcode field in bits 6:2
    localparam logic [4:0] opc_load     = 5'b00000;
    localparam logic [4:0] opc_load_fp  = 5'b00001;
    localparam logic [4:0] opc_op_imm   = 5'b00100;
    localparam logic [4:0] opc_auipc    = 5'b00101;
    localparam logic [4:0] opc_store    = 5'b01000;
    localparam logic [4:0] opc_store_fp = 5'b01001;
    localparam logic [4:0] opc_op       = 5'b01100;
    localparam logic [4:0] opc_lui      = 5'b01101;
    localparam logic [4:0] opc_branch   = 5'b11000;
    localparam logic [4:0] opc_jalr     = 5'b11001;
    localparam logic [4:0] opc_jal      = 5'b11011;
    localparam logic [4:0] opc_system   = 5'b11100;

    localparam logic [1:0] opc_full     = 2'b11;    // 32-bit encoding marker

    // funct3 values
    localparam logic [2:0] f3_add       = 3'b000;   // add/sub, addi
    localparam logic [2:0] f3_sll       = 3'b001;
    localparam logic [2:0] f3_slt       = 3'b010;
    localparam logic [2:0] f3_sltu      = 3'b011;
    localparam logic [2:0] f3_xor       = 3'b100;
    localparam logic [2:0] f3_sr        = 3'b101;   // srl/sra
    localparam logic [2:0] f3_or        = 3'b110;
    localparam logic [2:0] f3_and       = 3'b111;
    localparam logic [2:0] f3_jalr      = 3'b000;
    localparam logic [2:0] f3_priv      = 3'b000;   // ecall, ebreak, mret

    // funct12 of the privileged system words
    localparam logic [11:0] f12_ecall   = 12'h000;
    localparam logic [11:0] f12_ebreak  = 12'h001;
    localparam logic [11:0] f12_mret    = 12'h302;

    typedef logic [31:0] instr_t;

    typedef enum logic [3:0] {
        cls_none,
        cls_load,
        cls_store,
        cls_op_imm,
        cls_op,
        cls_lui,
        cls_auipc,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_system
    } opc_class_e;

    typedef enum logic [2:0] {
        sys_none,
        sys_ecall,
        sys_ebreak,
        sys_mret,
        sys_csr
    } sys_op_e;

    typedef struct packed {
        logic add_override;
        logic op1_inv_or_ecmp_inv;
        logic op2_inverse;
    } alu_ctrl_t;

    // one-hot or zero
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed {
        logic j;
        logic i;
        logic r;
    } op2_src_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic [11:0] idx;
        logic [4:0]  imm;
        logic        imm_sel;
        logic        write;
        logic        set;
        logic        clear;
        logic        read;
    } csr_ctrl_t;

endpackage

`default_nettype wire

// ==== hdl/rv_decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_decode_top
#(
    parameter int   PC_BITS  = 32,
    parameter logic ZICSR_EN = 1'b1
)
(
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  wire                      i_stall,
    input  wire                      i_flush,
    input  wire                      i_ready,
    input  rv_decode_pkg::instr_t    i_instruction,
    input  wire  [PC_BITS-1:1]       i_pc,
    input  wire  [PC_BITS-1:1]       i_pc_next,
    output logic [PC_BITS-1:1]       o_pc,
    output logic [PC_BITS-1:1]       o_pc_next,
    output logic [4:0]               o_rs1,
    output logic [4:0]               o_rs2,
    output logic [4:0]               o_rd,
    output logic [31:0]              o_imm_i,
    output logic [31:0]              o_imm_j,
    output logic [2:0]               o_funct3,
    output rv_decode_pkg::alu_ctrl_t o_alu_ctrl,
    output rv_decode_pkg::alu_res_t  o_alu_res,
    output logic                     o_op1_src,
    output rv_decode_pkg::op2_src_t  o_op2_src,
    output rv_decode_pkg::res_src_t  o_res_src,
    output logic                     o_reg_write,
    output rv_decode_pkg::csr_ctrl_t o_csr,
    output logic                     o_csr_ebreak,
    output logic                     o_inst_mret,
    output logic                     o_inst_csr_req,
    output logic                     o_inst_jal,
    output logic                     o_inst_jalr,
    output logic                     o_inst_branch,
    output logic                     o_inst_store,
    output logic                     o_inst_supported
);
    import rv_decode_pkg::*;

    instr_t     instr;      // registered word
    logic       valid;
    opc_class_e cls;
    sys_op_e    sys_op;

    rv_instr_reg #(.PC_BITS(PC_BITS)) u_instr_reg (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .i_ready       (i_ready),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .o_instr       (instr),
        .o_valid       (valid),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next)
    );

    rv_opcode_decode #(.ZICSR_EN(ZICSR_EN)) u_opcode_decode (
        .i_instr          (instr),
        .i_valid          (valid),
        .o_class          (cls),
        .o_sys_op         (sys_op),
        .o_rs1            (o_rs1),
        .o_reg_write      (o_reg_write),
        .o_op1_src        (o_op1_src),
        .o_op2_src        (o_op2_src),
        .o_res_src        (o_res_src),
        .o_inst_supported (o_inst_supported)
    );

    rv_imm_gen u_imm_gen (
        .i_instr (instr),
        .i_class (cls),
        .o_imm_i (o_imm_i),
        .o_imm_j (o_imm_j)
    );

    rv_alu_ctrl u_alu_ctrl (
        .i_instr    (instr),
        .i_class    (cls),
        .o_alu_ctrl (o_alu_ctrl),
        .o_alu_res  (o_alu_res)
    );

    rv_csr_ctrl u_csr_ctrl (
        .i_instr        (instr),
        .i_sys_op       (sys_op),
        .i_stall        (i_stall),
        .o_csr          (o_csr),
        .o_csr_ebreak   (o_csr_ebreak),
        .o_inst_mret    (o_inst_mret),
        .o_inst_csr_req (o_inst_csr_req)
    );

    assign o_rd     = instr[11:7];
    assign o_rs2    = instr[24:20];
    assign o_funct3 = instr[14:12];

    assign o_inst_jal    = (cls == cls_jal);
    assign o_inst_jalr   = (cls == cls_jalr);
    assign o_inst_branch = (cls == cls_branch);
    assign o_inst_store  = (cls == cls_store);

endmodule

`default_nettype wire

// ==== hdl/rv_imm_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_imm_gen
(
    input  rv_decode_pkg::instr_t     i_instr,
    input  rv_decode_pkg::opc_class_e i_class,
    output logic [31:0]               o_imm_i,
    output logic [31:0]               o_imm_j
);
    import rv_decode_pkg::*;

    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'd0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // operand immediate
    always_comb
    begin
        if ((i_class == cls_lui) || (i_class == cls_auipc))
            o_imm_i = imm_u;
        else if (i_class == cls_store)
            o_imm_i = imm_s;
        else
            o_imm_i = imm_i;
    end

    assign o_imm_j = (i_class == cls_jal) ? imm_j : imm_b;  // jump or branch offset

endmodule

`default_nettype wire

// ==== hdl/rv_instr_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_instr_reg
#(
    parameter int PC_BITS = 32
)
(
    input  wire                   i_clk,
    input  wire                   i_arst_n,
    input  wire                   i_stall,
    input  wire                   i_flush,
    input  wire                   i_ready,
    input  rv_decode_pkg::instr_t i_instruction,
    input  wire  [PC_BITS-1:1]    i_pc,
    input  wire  [PC_BITS-1:1]    i_pc_next,
    output rv_decode_pkg::instr_t o_instr,
    output logic                  o_valid,
    output logic [PC_BITS-1:1]    o_pc,
    output logic [PC_BITS-1:1]    o_pc_next
);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_instr   <= '0;
            o_valid   <= 1'b0;
            o_pc      <= '0;
            o_pc_next <= '0;
        end
        else if (i_flush)
        begin
            // pc and next pc hold on flush
            o_instr <= '0;
            o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instr   <= i_ready ? i_instruction : '0;  // bubble when fetch not ready
            o_valid   <= i_ready;
            o_pc      <= i_pc;
            o_pc_next <= i_pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_opcode_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_opcode_decode
#(
    parameter logic ZICSR_EN = 1'b1
)
(
    input  rv_decode_pkg::instr_t      i_instr,
    input  wire                        i_valid,
    output rv_decode_pkg::opc_class_e  o_class,
    output rv_decode_pkg::sys_op_e     o_sys_op,
    output logic [4:0]                 o_rs1,
    output logic                       o_reg_write,
    output logic                       o_op1_src,
    output rv_decode_pkg::op2_src_t    o_op2_src,
    output rv_decode_pkg::res_src_t    o_res_src,
    output logic                       o_inst_supported
);
    import rv_decode_pkg::*;

    logic [4:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic        full;
    logic        is_load, is_store, is_op_imm, is_lui, is_auipc, is_jal, is_jalr;
    logic        base_ok, sys_ok, zicsr_ok;

    assign opcode  = i_instr[6:2];
    assign funct3  = i_instr[14:12];
    assign funct12 = i_instr[31:20];
    assign full    = (i_instr[1:0] == opc_full);

    always_comb
    begin
        o_class = cls_none;
        if (full)
        begin
            case (opcode)
                opc_load:     o_class = cls_load;
                opc_store:    o_class = cls_store;
                opc_op_imm:   o_class = cls_op_imm;
                opc_op:       o_class = i_instr[25] ? cls_none : cls_op;  // no M extension
                opc_lui:      o_class = cls_lui;
                opc_auipc:    o_class = cls_auipc;
                opc_branch:   o_class = cls_branch;
                opc_jal:      o_class = cls_jal;
                opc_jalr:     o_class = (funct3 == f3_jalr) ? cls_jalr : cls_none;
                opc_system:   o_class = cls_system;
                opc_load_fp,
                opc_store_fp: o_class = cls_none;  // no F extension
                default:      o_class = cls_none;
            endcase
        end
    end

    always_comb
    begin
        o_sys_op = sys_none;
        if (o_class == cls_system)
        begin
            if (funct3 != f3_priv)
                o_sys_op = sys_csr;
            else
            begin
                case (funct12)
                    f12_ecall:  o_sys_op = sys_ecall;
                    f12_ebreak: o_sys_op = sys_ebreak;
                    f12_mret:   o_sys_op = sys_mret;
                    default:    o_sys_op = sys_none;
                endcase
            end
        end
    end

    assign is_load   = (o_class == cls_load);
    assign is_store  = (o_class == cls_store);
    assign is_op_imm = (o_class == cls_op_imm);
    assign is_lui    = (o_class == cls_lui);
    assign is_auipc  = (o_class == cls_auipc);
    assign is_jal    = (o_class == cls_jal);
    assign is_jalr   = (o_class == cls_jalr);

    // any full-length word writes rd unless it has no rd field
    assign o_reg_write = full & !((opcode == opc_branch) |
                                  (opcode == opc_store) |
                                  (opcode == opc_store_fp));

    assign o_rs1     = is_lui ? 5'd0 : i_instr[19:15];  // lui adds to x0
    assign o_op1_src = is_auipc | is_jal;               // pc as operand 1

    assign o_op2_src.j = is_jal;
    assign o_op2_src.i = is_jalr | is_load | is_op_imm | is_lui | is_auipc | is_store;
    assign o_op2_src.r = !(is_jal | is_jalr | is_load | is_op_imm | is_lui |
                           is_auipc | is_store);

    assign o_res_src.memory  = is_load;
    assign o_res_src.pc_next = is_jal | is_jalr;  // link address
    assign o_res_src.alu     = !(is_load | is_jal | is_jalr);

    // system words are supported only per sub-op
    assign base_ok  = (o_class != cls_none) && (o_class != cls_system);
    assign sys_ok   = (o_sys_op == sys_ecall) || (o_sys_op == sys_ebreak);
    assign zicsr_ok = ZICSR_EN && ((o_sys_op == sys_csr) || (o_sys_op == sys_mret));

    assign o_inst_supported = !i_valid | base_ok | sys_ok | zicsr_ok;

endmodule

`default_nettype wire

// ==== project.f ====
hdl/rv_decode_pkg.sv
hdl/rv_instr_reg.sv
hdl/rv_opcode_decode.sv
hdl/rv_imm_gen.sv
hdl/rv_alu_ctrl.sv
hdl/rv_csr_ctrl.sv
hdl/rv_decode_top.sv
testbench/rv_decode_assert.sv
testbench/tb_rv_decode.sv

// ==== testbench/rv_decode_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_decode_assert
(
    input wire                       i_clk,
    input wire                       i_arst_n,
    input wire                       i_stall,
    input rv_decode_pkg::instr_t     i_instr,
    input rv_decode_pkg::alu_res_t   i_alu_res,
    input rv_decode_pkg::op2_src_t   i_op2_src,
    input rv_decode_pkg::csr_ctrl_t  i_csr,
    input wire                       i_reg_write
);

    result_group_onehot0 : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(i_alu_res))
        else $error("alu result group not one-hot or zero: %b", i_alu_res);

    csr_strobes_stall : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_stall |-> !(i_csr.write || i_csr.set || i_csr.clear))
        else $error("csr strobe active while stalled");

    // bubble never writes a register
    zero_word_no_write : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_instr == '0) |-> !i_reg_write)
        else $error("reg_write high for a zero word");

    op2_src_onehot : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot(i_op2_src))
        else $error("op2_src not one-hot: %b", i_op2_src);

endmodule

bind rv_decode_top rv_decode_assert u_decode_assert (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_stall     (i_stall),
    .i_instr     (instr),
    .i_alu_res   (o_alu_res),
    .i_op2_src   (o_op2_src),
    .i_csr       (o_csr),
    .i_reg_write (o_reg_write)
);

`default_nettype wire

// ==== testbench/tb_rv_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_decode;
    import rv_decode_pkg::*;

    localparam int     PC_BITS    = 32;
    localparam logic   ZICSR_EN   = 1'b1;
    localparam int     CLK_PERIOD = 40;
    localparam int     N_RANDOM   = 400;
    localparam int     N_DIRECTED = 40;     // reset plus directed steps rounded up
    localparam int     N_TESTS    = N_RANDOM + N_DIRECTED;
    localparam instr_t NOP        = 32'h00000013;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        alu_ctrl_t   alu_ctrl;
        alu_res_t    alu_res;
        logic        op1_src;
        op2_src_t    op2_src;
        res_src_t    res_src;
        logic        reg_write;
        csr_ctrl_t   csr;
        logic        ebreak;
        logic        mret;
        logic        csr_req;
        logic        jal;
        logic        jalr;
        logic        branch;
        logic        store;
        logic        supported;
    } exp_t;

    logic               i_clk, i_arst_n, i_stall, i_flush, i_ready;
    instr_t             i_instruction;
    logic [PC_BITS-1:1] i_pc, i_pc_next, o_pc, o_pc_next;
    logic [4:0]         o_rs1, o_rs2, o_rd;
    logic [31:0]        o_imm_i, o_imm_j;
    logic [2:0]         o_funct3;
    alu_ctrl_t          o_alu_ctrl;
    alu_res_t           o_alu_res;
    op2_src_t           o_op2_src;
    res_src_t           o_res_src;
    csr_ctrl_t          o_csr;
    logic               o_op1_src, o_reg_write, o_csr_ebreak, o_inst_mret, o_inst_csr_req;
    logic               o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store, o_inst_supported;

    // model of the instruction register
    instr_t             m_instr;
    logic               m_valid;
    logic [PC_BITS-1:1] m_pc, m_pc_next;

    integer seed;
    int     n_checks;
    int     n_errors;

    rv_decode_top #(.PC_BITS(PC_BITS), .ZICSR_EN(ZICSR_EN)) uut (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial
    begin
        #((N_TESTS + 20) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", N_TESTS + 20);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_alu_ctrl(input string name, input alu_ctrl_t got, input alu_ctrl_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_alu_res(input string name, input alu_res_t got, input alu_res_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_csr(input string name, input csr_ctrl_t got, input csr_ctrl_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            n_errors++;
        end
    endtask

    function automatic exp_t model_decode(input instr_t w, input logic valid, input logic stall);
        exp_t       e;
        opc_class_e c;
        sys_op_e    s;
        logic [2:0] f3;
        logic       full;
        logic       alu_cls;
        logic       csr;
        f3   = w[14:12];
        full = (w[1:0] == opc_full);
        c    = cls_none;
        if (full)
        begin
            case (w[6:2])
                opc_load:   c = cls_load;
                opc_store:  c = cls_store;
                opc_op_imm: c = cls_op_imm;
                opc_op:     if (!w[25]) c = cls_op;   // funct7 bit 0 is M
                opc_lui:    c = cls_lui;
                opc_auipc:  c = cls_auipc;
                opc_branch: c = cls_branch;
                opc_jal:    c = cls_jal;
                opc_jalr:   if (f3 == 3'd0) c = cls_jalr;
                opc_system: c = cls_system;
                default:    c = cls_none;
            endcase
        end
        s = sys_none;
        if (c == cls_system)
        begin
            if (f3 != 3'd0)
                s = sys_csr;
            else if (w[31:20] == 12'h000)
                s = sys_ecall;
            else if (w[31:20] == 12'h001)
                s = sys_ebreak;
            else if (w[31:20] == 12'h302)
                s = sys_mret;
        end
        alu_cls = c inside {cls_op, cls_op_imm};
        csr     = (s == sys_csr);
        e       = '0;
        e.rs1       = (c == cls_lui) ? 5'd0 : w[19:15];
        e.reg_write = full && !(w[6:2] inside {opc_branch, opc_store, opc_store_fp});
        e.op1_src   = c inside {cls_auipc, cls_jal};
        e.op2_src.j = (c == cls_jal);
        e.op2_src.i = c inside {cls_jalr, cls_load, cls_op_imm, cls_lui, cls_auipc, cls_store};
        e.op2_src.r = !(e.op2_src.j || e.op2_src.i);
        e.res_src.memory  = (c == cls_load);
        e.res_src.pc_next = c inside {cls_jal, cls_jalr};
        e.res_src.alu     = !(e.res_src.memory || e.res_src.pc_next);
        case (c)
            cls_lui, cls_auipc: e.imm_i = {w[31:12], 12'd0};
            cls_store:          e.imm_i = {{20{w[31]}}, w[31:25], w[11:7]};
            default:            e.imm_i = {{20{w[31]}}, w[31:20]};
        endcase
        if (c == cls_jal)
            e.imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        else
            e.imm_j = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.alu_ctrl.add_override = c inside {cls_lui, cls_auipc, cls_jal, cls_load, cls_store};
        e.alu_ctrl.op1_inv_or_ecmp_inv = (c == cls_branch) && f3[0];
        if ((c == cls_branch) || (alu_cls && (f3 inside {f3_slt, f3_sltu})) ||
            (alu_cls && (f3 == f3_sr) && w[30]))
            e.alu_ctrl.op2_inverse = 1'b1;
        else if (c inside {cls_lui, cls_auipc, cls_jal, cls_load, cls_store, cls_op_imm})
            e.alu_ctrl.op2_inverse = 1'b0;
        else
            e.alu_ctrl.op2_inverse = w[30];
        if (c == cls_branch)
            e.alu_res.cmp = 1'b1;
        else if (c inside {cls_load, cls_store})
            e.alu_res.arith = 1'b1;
        else if (alu_cls)
        begin
            case (f3)
                f3_add:          e.alu_res.arith = (c == cls_op);
                f3_sll, f3_sr:   e.alu_res.shift = 1'b1;
                f3_slt, f3_sltu: e.alu_res.cmp = 1'b1;
                default:         e.alu_res.bits = 1'b1;
            endcase
        end
        e.csr.idx     = w[31:20];
        e.csr.imm     = w[19:15];
        e.csr.imm_sel = f3[2];
        e.csr.read    = csr;
        e.csr.write   = csr && !stall && (f3[1:0] == 2'b01);
        e.csr.set     = csr && !stall && (f3[1:0] == 2'b10);
        e.csr.clear   = csr && !stall && (f3[1:0] == 2'b11);
        e.csr_req     = csr;
        e.ebreak      = (s == sys_ebreak);
        e.mret        = (s == sys_mret);
        e.jal         = (c == cls_jal);
        e.jalr        = (c == cls_jalr);
        e.branch      = (c == cls_branch);
        e.store       = (c == cls_store);
        e.supported   = !valid || ((c != cls_none) && (c != cls_system)) ||
                        (s inside {sys_ecall, sys_ebreak}) ||
                        (ZICSR_EN && (s inside {sys_csr, sys_mret}));
        return e;
    endfunction

    function automatic instr_t with_opcode(input instr_t w, input logic [4:0] opc);
        return {w[31:7], opc, opc_full};
    endfunction

    function automatic logic one_in(input int n);
        return ($unsigned($random(seed)) % n) == 0;
    endfunction

    function automatic instr_t system_word(input instr_t w);
        instr_t s;
        s = with_opcode(w, opc_system);
        if (w[6])
        begin
            s[14:12] = 3'b000;
            case (w[21:20])
                2'd0:    s[31:20] = 12'h000;
                2'd1:    s[31:20] = 12'h001;
                2'd2:    s[31:20] = 12'h302;
                default: ;   // unknown privileged word
            endcase
        end
        return s;
    endfunction

    function automatic instr_t gen_word();
        instr_t w;
        int     pick;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 16;
        if (pick < 8)
        begin
            case ($unsigned($random(seed)) % 10)
                0:       w = with_opcode(w, opc_load);
                1:       w = with_opcode(w, opc_op_imm);
                2:       w = with_opcode(w, opc_auipc);
                3:       w = with_opcode(w, opc_store);
                4:       w = with_opcode(w, opc_op);
                5:       w = with_opcode(w, opc_lui);
                6:       w = with_opcode(w, opc_branch);
                7:       w = with_opcode(w, opc_jalr);
                8:       w = with_opcode(w, opc_jal);
                default: w = with_opcode(w, opc_system);
            endcase
        end
        else if (pick < 11)
            w = system_word(w);
        else if (pick < 13)
            w = with_opcode(w, w[7] ? opc_store_fp : opc_load_fp);
        return w;   // fully random otherwise
    endfunction

    task automatic update_model();
        if (!i_arst_n)
        begin
            m_instr   = '0;
            m_valid   = 1'b0;
            m_pc      = '0;
            m_pc_next = '0;
        end
        else if (i_flush)
        begin
            m_instr = '0;
            m_valid = 1'b0;
        end
        else if (!i_stall)
        begin
            m_instr   = i_ready ? i_instruction : '0;
            m_valid   = i_ready;
            m_pc      = i_pc;
            m_pc_next = i_pc_next;
        end
    endtask

    task automatic check_outputs();
        exp_t e;
        e = model_decode(m_instr, m_valid, i_stall);
        check_word("o_pc", 32'(o_pc), 32'(m_pc));
        check_word("o_pc_next", 32'(o_pc_next), 32'(m_pc_next));
        check_word("o_rs1", 32'(o_rs1), 32'(e.rs1));
        check_word("o_rs2", 32'(o_rs2), 32'(m_instr[24:20]));
        check_word("o_rd", 32'(o_rd), 32'(m_instr[11:7]));
        check_word("o_funct3", 32'(o_funct3), 32'(m_instr[14:12]));
        check_word("o_imm_i", o_imm_i, e.imm_i);
        check_word("o_imm_j", o_imm_j, e.imm_j);
        check_alu_ctrl("o_alu_ctrl", o_alu_ctrl, e.alu_ctrl);
        check_alu_res("o_alu_res", o_alu_res, e.alu_res);
        check_bit("o_op1_src", o_op1_src, e.op1_src);
        check_word("o_op2_src", 32'(o_op2_src), 32'(e.op2_src));
        check_word("o_res_src", 32'(o_res_src), 32'(e.res_src));
        check_bit("o_reg_write", o_reg_write, e.reg_write);
        check_csr("o_csr", o_csr, e.csr);
        check_bit("o_csr_ebreak", o_csr_ebreak, e.ebreak);
        check_bit("o_inst_mret", o_inst_mret, e.mret);
        check_bit("o_inst_csr_req", o_inst_csr_req, e.csr_req);
        check_bit("o_inst_jal", o_inst_jal, e.jal);
        check_bit("o_inst_jalr", o_inst_jalr, e.jalr);
        check_bit("o_inst_branch", o_inst_branch, e.branch);
        check_bit("o_inst_store", o_inst_store, e.store);
        check_bit("o_inst_supported", o_inst_supported, e.supported);
    endtask

    // model samples the old inputs before the new ones go out
    task automatic step(input logic stall, input logic flush, input logic ready, input instr_t w);
        logic [31:0] pc_rand;
        @(posedge i_clk);
        update_model();
        pc_rand = $random(seed);
        i_stall       <= stall;
        i_flush       <= flush;
        i_ready       <= ready;
        i_instruction <= w;
        i_pc          <= pc_rand[PC_BITS-1:1];
        i_pc_next     <= pc_rand[PC_BITS-1:1] + 2'd2;
        @(negedge i_clk);
        check_outputs();
    endtask

    task automatic decode_unsupported(input instr_t w);
        step(1'b0, 1'b0, 1'b1, w);
        step(1'b0, 1'b0, 1'b1, NOP);
        check_bit("o_inst_supported", o_inst_supported, 1'b0);
    endtask

    initial
    begin
        instr_t w;
        seed          = 32'hdbe36597;
        n_checks      = 0;
        n_errors      = 0;
        i_arst_n      = 1'b0;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        i_pc_next     = '0;
        update_model();
        repeat (8) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        check_bit("o_reg_write", o_reg_write, 1'b0);
        check_csr("o_csr", o_csr, '0);
        check_bit("o_inst_jal", o_inst_jal, 1'b0);
        check_bit("o_inst_jalr", o_inst_jalr, 1'b0);
        check_bit("o_inst_branch", o_inst_branch, 1'b0);
        check_bit("o_inst_store", o_inst_store, 1'b0);
        check_bit("o_inst_mret", o_inst_mret, 1'b0);
        check_bit("o_inst_supported", o_inst_supported, 1'b1);

        for (int k = 0; k < N_RANDOM; k++)
            step(one_in(8), one_in(16), !one_in(8), gen_word());

        // ready low and then flush under stall give a zero word
        step(1'b0, 1'b0, 1'b0, gen_word());
        step(1'b0, 1'b0, 1'b1, gen_word());
        check_bit("o_inst_supported", o_inst_supported, 1'b1);
        check_bit("o_reg_write", o_reg_write, 1'b0);
        step(1'b1, 1'b1, 1'b1, gen_word());
        step(1'b0, 1'b0, 1'b1, NOP);
        check_bit("o_inst_supported", o_inst_supported, 1'b1);
        check_bit("o_reg_write", o_reg_write, 1'b0);

        // csrrw x1, 0x300, x5 held by stall
        step(1'b0, 1'b0, 1'b1, 32'h300290f3);
        step(1'b1, 1'b0, 1'b1, gen_word());
        check_bit("o_csr.write", o_csr.write, 1'b0);
        step(1'b1, 1'b0, 1'b1, gen_word());
        step(1'b0, 1'b0, 1'b1, NOP);
        check_bit("o_csr.write", o_csr.write, 1'b1);

        for (int f = 1; f < 8; f++)
        begin
            w = $random(seed);
            w[14:12] = f[2:0];
            step(1'b0, 1'b0, 1'b1, with_opcode(w, opc_system));
        end
        step(1'b0, 1'b0, 1'b1, 32'h00000073);   // ecall
        step(1'b0, 1'b0, 1'b1, 32'h00100073);   // ebreak
        step(1'b0, 1'b0, 1'b1, 32'h30200073);   // mret
        check_bit("o_csr_ebreak", o_csr_ebreak, 1'b1);
        step(1'b0, 1'b0, 1'b1, NOP);
        check_bit("o_inst_mret", o_inst_mret, 1'b1);

        w = $random(seed);
        decode_unsupported(with_opcode(w, opc_load_fp));
        decode_unsupported(with_opcode(w, opc_store_fp));
        decode_unsupported(with_opcode(w, 5'b00010));   // custom-0
        w[14:12] = 3'b001;
        decode_unsupported(with_opcode(w, opc_jalr));
        w[25] = 1'b1;
        decode_unsupported(with_opcode(w, opc_op));
        step(1'b0, 1'b0, 1'b1, NOP);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
